//--- design/dircc_pkg.sv
package dircc_pkg;

    localparam int num_devices = 8;
    localparam int address_width = 3;
    localparam logic [15:0] tick_limit = 16'd4;

    // one-hot flags in the 4-bit dircc_state field.
    localparam logic [3:0] dircc_state_done = 4'b0001;
    localparam logic [3:0] dircc_state_stopped = 4'b0010;

    typedef struct packed {
        logic [15:0] rts;   // ticks still to send.
        logic [15:0] count; // ticks received.
    } user_state_t;

    typedef struct packed {
        logic [3:0] dircc_state;
        user_state_t user_state;
    } device_state_t;

    typedef struct packed {
        logic [address_width-1:0] address;
        logic [15:0] count;
        logic is_final;
    } packet_data_t;

    // Handler side of one state memory transaction.
    typedef enum logic [1:0] {
        xact_idle,
        xact_req,
        xact_read,
        xact_write
    } xact_state_t;

endpackage : dircc_pkg

//--- design/dircc_state_if.sv
`timescale 1ns/1ps

interface dircc_state_if;
    import dircc_pkg::*;

    logic req;
    logic grant;
    logic [address_width-1:0] address;
    device_state_t read_state;
    device_state_t write_state;
    logic write_state_valid;

    modport client (
        output req,
        output address,
        output write_state,
        output write_state_valid,
        input grant,
        input read_state
    );

    modport arbiter (
        input req,
        input address,
        input write_state,
        input write_state_valid,
        output grant,
        output read_state
    );

endinterface : dircc_state_if

//--- design/dircc_state_mem.sv
`timescale 1ns/1ps

module dircc_state_mem (
    input logic clk,
    input logic reset_n,
    input logic [dircc_pkg::address_width-1:0] address,
    input logic write_valid,
    input dircc_pkg::device_state_t write_state,
    output dircc_pkg::device_state_t read_state
);
    import dircc_pkg::*;

    device_state_t states [num_devices];

    // read is registered. a write in the same cycle is seen next access.
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < num_devices; i++) begin
                states[i] <= '0;
            end
            read_state <= '0;
        end else begin
            if (write_valid) begin
                states[address] <= write_state;
            end
            read_state <= states[address];
        end
    end

endmodule : dircc_state_mem

//--- design/dircc_state_arbiter.sv
`timescale 1ns/1ps

module dircc_state_arbiter (
    input logic clk,
    input logic reset_n,
    dircc_state_if.arbiter send_port,
    dircc_state_if.arbiter recv_port,
    output logic [dircc_pkg::address_width-1:0] mem_address,
    output logic mem_write_valid,
    output dircc_pkg::device_state_t mem_write_state,
    input dircc_pkg::device_state_t mem_read_state
);
    import dircc_pkg::*;

    logic active;      // a grant is held.
    logic owner_recv;  // current owner or last owner while idle.
    logic pick_recv;
    logic owner_req;

    // recv wins a tie only if send held the last grant.
    assign pick_recv = recv_port.req && (!send_port.req || !owner_recv);
    assign owner_req = owner_recv ? recv_port.req : send_port.req;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            active <= 1'b0;
            owner_recv <= 1'b0;
        end else if (active) begin
            if (!owner_req) begin
                active <= 1'b0; // release and pass priority on.
            end
        end else if (send_port.req || recv_port.req) begin
            active <= 1'b1;
            owner_recv <= pick_recv;
        end
    end

    assign send_port.grant = active && !owner_recv;
    assign recv_port.grant = active && owner_recv;

    always_comb begin
        if (owner_recv) begin
            mem_address = recv_port.address;
            mem_write_state = recv_port.write_state;
            mem_write_valid = active && recv_port.write_state_valid;
        end else begin
            mem_address = send_port.address;
            mem_write_state = send_port.write_state;
            mem_write_valid = active && send_port.write_state_valid;
        end
    end

    // both see the data but only the owner takes it.
    assign send_port.read_state = mem_read_state;
    assign recv_port.read_state = mem_read_state;

endmodule : dircc_state_arbiter

//--- design/dircc_send_handler.sv
`timescale 1ns/1ps

module dircc_send_handler (
    input logic clk,
    input logic reset_n,
    dircc_state_if.client state_port,
    output dircc_pkg::packet_data_t packet_out,
    output logic packet_out_valid
);
    import dircc_pkg::*;

    xact_state_t state;
    logic [address_width-1:0] scan_addr;
    user_state_t cur_user;
    logic has_rts;
    logic last_packet;
    device_state_t next_state;

    assign cur_user = state_port.read_state.user_state;
    assign has_rts = cur_user.rts != 16'd0;

    // last outstanding tick of a finished device.
    assign last_packet = (cur_user.rts == 16'd1) &&
                         ((state_port.read_state.dircc_state & dircc_state_done) != 4'b0);

    always_comb begin
        next_state.dircc_state = state_port.read_state.dircc_state;
        next_state.user_state.rts = cur_user.rts - 16'd1;
        next_state.user_state.count = cur_user.count;
        if (last_packet) begin
            next_state.dircc_state = dircc_state_done | dircc_state_stopped;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state <= xact_idle;
            scan_addr <= '0;
            state_port.write_state_valid <= 1'b0;
            packet_out_valid <= 1'b0;
        end else begin
            state_port.write_state_valid <= 1'b0;
            packet_out_valid <= 1'b0;
            case (state)
                xact_idle: state <= xact_req;
                xact_req: if (state_port.grant) state <= xact_read;
                xact_read: begin
                    state_port.write_state_valid <= has_rts; // skip on zero rts.
                    packet_out_valid <= has_rts;
                    state <= xact_write;
                end
                default: begin
                    scan_addr <= scan_addr + 1'b1; // next device.
                    state <= xact_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == xact_read) begin
            state_port.write_state <= next_state;
            packet_out.address <= scan_addr;
            packet_out.count <= cur_user.count;
            packet_out.is_final <= last_packet;
        end
    end

    assign state_port.req = (state == xact_req) || (state == xact_read);
    assign state_port.address = scan_addr;

endmodule : dircc_send_handler

//--- design/dircc_recv_handler.sv
`timescale 1ns/1ps

module dircc_recv_handler (
    input logic clk,
    input logic reset_n,
    input dircc_pkg::packet_data_t packet_in,
    input logic packet_in_valid,
    output logic recv_busy,
    dircc_state_if.client state_port
);
    import dircc_pkg::*;

    xact_state_t state;
    logic [address_width-1:0] dest_addr;
    user_state_t cur_user;
    logic stopped;
    logic [15:0] new_count;
    device_state_t next_state;

    assign cur_user = state_port.read_state.user_state;
    assign stopped = (state_port.read_state.dircc_state & dircc_state_stopped) != 4'b0;
    assign new_count = cur_user.count + 16'd1;

    always_comb begin
        next_state.dircc_state = state_port.read_state.dircc_state;
        next_state.user_state.rts = cur_user.rts + 16'd1;
        next_state.user_state.count = new_count;
        if (new_count == tick_limit) begin
            next_state.dircc_state = next_state.dircc_state | dircc_state_done;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state <= xact_idle;
            dest_addr <= '0;
            state_port.write_state_valid <= 1'b0;
        end else begin
            state_port.write_state_valid <= 1'b0;
            case (state)
                xact_idle: begin
                    if (packet_in_valid) begin
                        dest_addr <= packet_in.address;
                        state <= xact_req;
                    end
                end
                xact_req: if (state_port.grant) state <= xact_read;
                xact_read: begin
                    state_port.write_state_valid <= !stopped; // stopped stays as is.
                    state <= xact_write;
                end
                default: state <= xact_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == xact_read) begin
            state_port.write_state <= next_state;
        end
    end

    assign recv_busy = state != xact_idle; // strobes dropped while high.
    assign state_port.req = (state == xact_req) || (state == xact_read);
    assign state_port.address = dest_addr;

endmodule : dircc_recv_handler

//--- design/dircc_node.sv
`timescale 1ns/1ps

module dircc_node (
    input logic clk,
    input logic reset_n,
    input logic [dircc_pkg::address_width-1:0] in_address,
    input logic in_valid,
    output logic in_busy,
    output logic [dircc_pkg::address_width-1:0] out_address,
    output logic [15:0] out_count,
    output logic out_final,
    output logic out_valid
);
    import dircc_pkg::*;

    packet_data_t packet_in;
    packet_data_t packet_out;
    logic [address_width-1:0] mem_address;
    logic mem_write_valid;
    device_state_t mem_write_state;
    device_state_t mem_read_state;

    dircc_state_if send_if ();
    dircc_state_if recv_if ();

    // incoming ticks carry only a destination.
    assign packet_in.address = in_address;
    assign packet_in.count = 16'd0;
    assign packet_in.is_final = 1'b0;

    assign out_address = packet_out.address;
    assign out_count = packet_out.count;
    assign out_final = packet_out.is_final;

    dircc_state_mem u_state_mem (
        .clk(clk),
        .reset_n(reset_n),
        .address(mem_address),
        .write_valid(mem_write_valid),
        .write_state(mem_write_state),
        .read_state(mem_read_state)
    );

    dircc_state_arbiter u_state_arbiter (
        .clk(clk),
        .reset_n(reset_n),
        .send_port(send_if.arbiter),
        .recv_port(recv_if.arbiter),
        .mem_address(mem_address),
        .mem_write_valid(mem_write_valid),
        .mem_write_state(mem_write_state),
        .mem_read_state(mem_read_state)
    );

    dircc_send_handler u_send_handler (
        .clk(clk),
        .reset_n(reset_n),
        .state_port(send_if.client),
        .packet_out(packet_out),
        .packet_out_valid(out_valid)
    );

    dircc_recv_handler u_recv_handler (
        .clk(clk),
        .reset_n(reset_n),
        .packet_in(packet_in),
        .packet_in_valid(in_valid),
        .recv_busy(in_busy),
        .state_port(recv_if.client)
    );

endmodule : dircc_node

//--- tests/dircc_node_assert.sv
`timescale 1ns/1ps

module dircc_node_assert (
    input logic clk,
    input logic reset_n,
    input logic send_req,
    input logic recv_req,
    input logic send_grant,
    input logic recv_grant,
    input logic send_write,
    input logic recv_write,
    input logic mem_write,
    input logic packet_valid
);

    // one owner of the state memory at a time.
    single_writer: assert property (@(posedge clk) disable iff (!reset_n)
        !(send_write && recv_write)) else $error("both handlers write at once");

    send_write_granted: assert property (@(posedge clk) disable iff (!reset_n)
        send_write |-> send_grant) else $error("send write without grant");

    recv_write_granted: assert property (@(posedge clk) disable iff (!reset_n)
        recv_write |-> recv_grant) else $error("recv write without grant");

    // grant is held only until the owner drops req.
    send_grant_release: assert property (@(posedge clk) disable iff (!reset_n)
        send_grant && !send_req |=> !send_grant) else $error("send grant kept after release");

    recv_grant_release: assert property (@(posedge clk) disable iff (!reset_n)
        recv_grant && !recv_req |=> !recv_grant) else $error("recv grant kept after release");

    packet_with_write: assert property (@(posedge clk) disable iff (!reset_n)
        packet_valid == (mem_write && send_grant)) else $error("packet strobe apart from write");

endmodule : dircc_node_assert

bind dircc_node dircc_node_assert node_checks (
    .clk(clk),
    .reset_n(reset_n),
    .send_req(send_if.req),
    .recv_req(recv_if.req),
    .send_grant(send_if.grant),
    .recv_grant(recv_if.grant),
    .send_write(send_if.write_state_valid),
    .recv_write(recv_if.write_state_valid),
    .mem_write(mem_write_valid),
    .packet_valid(out_valid)
);

//--- tests/dircc_node_tb.sv
`timescale 1ns/1ps

module dircc_node_tb;
    import dircc_pkg::*;

    localparam int num_ticks = 80;
    localparam int busy_timeout = 40;
    localparam int drain_timeout = 4000;

    logic clk;
    logic reset_n;
    logic [address_width-1:0] in_address;
    logic in_valid;
    logic in_busy;
    logic [address_width-1:0] out_address;
    logic [15:0] out_count;
    logic out_final;
    logic out_valid;

    integer seed = 32'h100461a6;
    int received [num_devices]; // ticks written to the state memory.
    int sent [num_devices];
    logic done [num_devices];
    logic stopped [num_devices];
    logic pending;              // accepted tick whose write is not yet done.
    logic [address_width-1:0] pending_address;
    logic busy_seen;
    int packets_checked;

    dircc_node UUT (
        .clk(clk),
        .reset_n(reset_n),
        .in_address(in_address),
        .in_valid(in_valid),
        .in_busy(in_busy),
        .out_address(out_address),
        .out_count(out_count),
        .out_final(out_final),
        .out_valid(out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    // next packet a device owes from its tick totals.
    function automatic packet_data_t expected_packet(input logic [address_width-1:0] dev);
        packet_data_t pkt;
        pkt.address = dev;
        pkt.count = 16'(received[dev]);
        pkt.is_final = done[dev] && (received[dev] - sent[dev] == 1);
        return pkt;
    endfunction

    task automatic compare_packet(input packet_data_t got, input packet_data_t exp);
        if (got !== exp) begin
            $display("FAIL packet_out address/count/final: got %h %h %h, expected %h %h %h",
                     got.address, got.count, got.is_final,
                     exp.address, exp.count, exp.is_final);
            stop_with_failure();
        end
    endtask

    task automatic compare_user_state(input int dev, input user_state_t got,
                                      input user_state_t exp);
        if (got !== exp) begin
            $display("FAIL states[%0d].user_state: got %h, expected %h", dev, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic wait_not_busy();
        int waited;
        waited = 0;
        while (in_busy) begin
            if (waited == busy_timeout) begin
                $display("in_busy stayed high for %0d cycles", busy_timeout);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        logic all_sent;
        waited = 0;
        all_sent = 1'b0;
        while (!all_sent) begin
            if (waited == drain_timeout) begin
                $display("devices still had ticks to send after %0d cycles", drain_timeout);
                stop_with_failure();
            end
            @(posedge clk);
            waited++;
            all_sent = !pending;
            for (int d = 0; d < num_devices; d++) begin
                if (sent[d] != received[d]) all_sent = 1'b0;
            end
        end
    endtask

    // outputs are compared mid-cycle where they have settled.
    always @(negedge clk) begin
        packet_data_t got;
        packet_data_t exp;
        if (reset_n) begin
            if (pending && busy_seen && !in_busy) begin // its write was last cycle.
                if (!stopped[pending_address]) begin
                    received[pending_address]++;
                    if (received[pending_address] == int'(tick_limit)) done[pending_address] = 1'b1;
                end
                pending = 1'b0;
            end
            if (out_valid) begin
                if (sent[out_address] >= received[out_address]) begin
                    $display("packet for device %0d with no tick outstanding", out_address);
                    stop_with_failure();
                end
                got.address = out_address;
                got.count = out_count;
                got.is_final = out_final;
                exp = expected_packet(out_address);
                compare_packet(got, exp);
                sent[out_address]++;
                if (exp.is_final) stopped[out_address] = 1'b1;
                packets_checked++;
            end
            if (in_valid && !in_busy) begin
                pending = 1'b1;
                pending_address = in_address;
            end
            busy_seen = in_busy;
        end
    end

    initial begin
        int rnd;
        user_state_t exp_user;
        user_state_t got_user;
        reset_n = 1'b0;
        in_valid = 1'b0;
        in_address = '0;
        pending = 1'b0;
        busy_seen = 1'b0;
        packets_checked = 0;
        for (int d = 0; d < num_devices; d++) begin
            received[d] = 0;
            sent[d] = 0;
            done[d] = 1'b0;
            stopped[d] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        if (out_valid !== 1'b0 || in_busy !== 1'b0) begin
            $display("FAIL out_valid/in_busy after reset: got %h %h, expected 0 0",
                     out_valid, in_busy);
            stop_with_failure();
        end

        for (int n = 0; n < num_ticks; n++) begin
            wait_not_busy();
            rnd = $random(seed);
            in_address = rnd[2:0];
            in_valid = 1'b1;
            @(posedge clk);
            #1;
            rnd = $random(seed);
            in_valid = rnd[3]; // handler busy now, so this one is dropped.
            in_address = rnd[2:0];
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            repeat (rnd[5:4]) begin
                @(posedge clk);
                #1;
            end
        end

        wait_for_drain();
        @(negedge clk); // last write has landed.
        for (int d = 0; d < num_devices; d++) begin
            exp_user.rts = 16'(received[d] - sent[d]);
            exp_user.count = 16'(received[d]);
            got_user = UUT.u_state_mem.states[d].user_state;
            compare_user_state(d, got_user, exp_user);
        end

        if (packets_checked > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("no packets came out of the node");
            stop_with_failure();
        end
    end

endmodule : dircc_node_tb

//--- vlog.f
design/dircc_pkg.sv
design/dircc_state_if.sv
design/dircc_state_mem.sv
design/dircc_state_arbiter.sv
design/dircc_send_handler.sv
design/dircc_recv_handler.sv
design/dircc_node.sv
tests/dircc_node_assert.sv
tests/dircc_node_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the node testbench with Verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dircc_node_tb -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdircc_node_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "All checks passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
